// File: tests/pipe_testdata.txt
# I <instruction word>
# C <pc> <wen> <rd> <data>, all hex, the commit expected from the instruction above
I 20001401
C 1c000000 1 01 00000005
I 20000c22
C 1c000004 1 02 00000008
I 04000823
C 1c000008 1 03 0000000d
I 08000464
C 1c00000c 1 04 00000008
I 0c000865
C 1c000010 1 05 00000008
I 10000486
C 1c000014 1 06 0000000d
I 203ffc07
C 1c000018 1 07 ffffffff
# store then load of word 0x40, then a load-use
I 28010007
C 1c00001c 0 00 00000000
I 24010008
C 1c000020 1 08 ffffffff
I 04000509
C 1c000024 1 09 00000004
I 2800fc23
C 1c000028 0 00 00000000
I 2401100a
C 1c00002c 1 0a 0000000d
# CSRWR to save1 twice, a CSR-use, then an unmapped CSR
I 3000c4cb
C 1c000030 1 0b 00000000
I 3000c48c
C 1c000034 1 0c 0000000d
I 04002d8d
C 1c000038 1 0d 0000000d
I 3001002e
C 1c00003c 1 0e 00000000
# write to r0 and an unknown opcode retire without a write
I 20001c20
C 1c000040 0 00 00000000
I fc000021
C 1c000044 0 00 00000000
I 0400040f
C 1c000048 1 0f 00000005
I 3000c410
C 1c00004c 1 10 00000008

// File: tb.f
logic/core_pkg.sv
logic/reg_file.sv
logic/csr_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/pipe_top.sv
tests/pipe_sva.sv
tests/pipe_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run pipe_tb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module pipe_tb -f tb.f
	./obj_dir/Vpipe_tb > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Result: PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;

    logic        clk;
    logic        rst_n;
    logic        insn_valid;
    logic [31:0] insn;
    logic        insn_rdy;
    logic        commit_rdy;
    logic        commit_valid;
    logic        commit_wen;
    logic [31:0] commit_pc;
    logic [31:0] commit_data;
    logic [4:0]  commit_rd;

    // Instruction words and expected commits from the data file
    logic [31:0] insn_q[$];
    logic [31:0] exp_pc_q[$];
    logic [31:0] exp_wen_q[$];
    logic [31:0] exp_rd_q[$];
    logic [31:0] exp_data_q[$];

    integer seed;
    int     idx;
    int     n_done;
    int     total;
    int     cycles;
    int     limit;
    logic   took;

    pipe_top UUT (
        .clk, .rst_n, .insn_valid, .insn, .insn_rdy, .commit_rdy,
        .commit_valid, .commit_wen, .commit_pc, .commit_data, .commit_rd
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic load_testdata();
        int          fd;
        int          cnt;
        string       line;
        logic [31:0] f0, f1, f2, f3;
        fd = $fopen("tests/pipe_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open tests/pipe_testdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.getc(0) == "I") begin
                    cnt = $sscanf(line, "I %h", f0);
                    if (cnt != 1) begin
                        abort_run({"bad instruction line in test data: ", line});
                    end else begin
                        insn_q.push_back(f0);
                    end
                end else if (cnt > 0 && line.getc(0) == "C") begin
                    cnt = $sscanf(line, "C %h %h %h %h", f0, f1, f2, f3);
                    if (cnt != 4) begin
                        abort_run({"bad commit line in test data: ", line});
                    end else begin
                        exp_pc_q.push_back(f0);
                        exp_wen_q.push_back(f1);
                        exp_rd_q.push_back(f2);
                        exp_data_q.push_back(f3);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_commit();
        if (exp_pc_q.size() == 0) begin
            abort_run($sformatf("commit at pc %h has no expected entry", commit_pc));
        end else begin
            compare_value("commit_pc", commit_pc, exp_pc_q.pop_front());
            compare_value("commit_wen", {31'b0, commit_wen}, exp_wen_q.pop_front());
            compare_value("commit_rd", {27'b0, commit_rd}, exp_rd_q.pop_front());
            compare_value("commit_data", commit_data, exp_data_q.pop_front());
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        insn_valid = 1'b0;
        insn       = '0;
        commit_rdy = 1'b0;
        seed       = 32'he353_3782;
        idx        = 0;
        n_done     = 0;
        cycles     = 0;
        took       = 1'b0;

        load_testdata();
        total = exp_pc_q.size();
        limit = 20 * insn_q.size() + 100;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("insn_rdy", {31'b0, insn_rdy}, 32'd1);
        compare_value("commit_valid", {31'b0, commit_valid}, 32'd0);

        // Inputs change just after the rising edge and handshakes are sampled at the falling edge
        while (n_done < total && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (took || !insn_valid) begin
                insn_valid = (idx < insn_q.size()) && (($random(seed) % 4) != 0);
                insn       = (idx < insn_q.size()) ? insn_q[idx] : '0;
            end
            commit_rdy = ($random(seed) % 3) != 0;
            @(negedge clk);
            took = insn_valid && insn_rdy;
            if (took) begin
                idx++;
            end
            if (commit_valid && commit_rdy) begin
                check_commit();
                n_done++;
            end
        end

        if (n_done == total) begin
            @(posedge clk);
            #1;
            insn_valid = 1'b0;
            commit_rdy = 1'b1;
            // Nothing may retire after the last expected commit
            repeat (10) begin
                @(negedge clk);
                compare_value("commit_valid", {31'b0, commit_valid}, 32'd0);
            end
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run($sformatf("timeout after %0d cycles with %0d of %0d commits seen",
                                cycles, n_done, total));
        end
    end

endmodule

`default_nettype wire

// File: tests/pipe_sva.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_sva (
    input logic                           clk, rst_n,
    input logic                           commit_valid, commit_rdy, commit_wen, reg_we,
    input logic [core_pkg::xlen-1:0]      commit_pc, commit_data,
    input logic [core_pkg::reg_idx_w-1:0] commit_rd, reg_idx
);

    logic [core_pkg::xlen-1:0] next_pc;

    // Every accepted instruction retires once and in program order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc <= core_pkg::reset_pc;
        end else if (commit_valid && commit_rdy) begin
            next_pc <= commit_pc + 32'd4;
        end
    end

    pc_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |-> commit_pc == next_pc)
        else $error("commit_pc out of program order");

    commit_held: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid && !commit_rdy |=> commit_valid && $stable(commit_pc) &&
            $stable(commit_wen) && $stable(commit_rd) && $stable(commit_data))
        else $error("commit changed while it was stalled");

    no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        reg_we |-> reg_idx != '0)
        else $error("register write to r0");

endmodule

bind writeback_stage pipe_sva u_sva (
    .clk, .rst_n, .commit_valid, .commit_rdy, .commit_wen, .reg_we,
    .commit_pc, .commit_data, .commit_rd, .reg_idx
);

`default_nettype wire

// File: logic/pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_top (
    input  logic                           clk, rst_n,
    input  logic                           insn_valid,
    input  core_pkg::insn_u                insn,
    output logic                           insn_rdy,
    input  logic                           commit_rdy,
    output logic                           commit_valid, commit_wen,
    output logic [core_pkg::xlen-1:0]      commit_pc, commit_data,
    output logic [core_pkg::reg_idx_w-1:0] commit_rd
);

    logic [core_pkg::reg_idx_w-1:0]  rs1_idx, rs2_idx;
    logic [core_pkg::xlen-1:0]       rs1_data, rs2_data;

    logic                            id_valid, id_is_wr_rd, id_is_ld, id_is_st, id_is_csr;
    logic [core_pkg::xlen-1:0]       id_pc, id_rj_val, id_rk_val, id_imm;
    logic [core_pkg::op_w-1:0]       id_op;
    logic [core_pkg::reg_idx_w-1:0]  id_rd;
    logic [core_pkg::csr_addr_w-1:0] id_csr_addr;

    logic                            ex_rdy, ex_valid, ex_is_wr_rd, ex_is_ld, ex_is_st, ex_is_csr;
    logic [core_pkg::xlen-1:0]       ex_pc, ex_result, ex_st_data;
    logic [core_pkg::reg_idx_w-1:0]  ex_rd;
    logic [core_pkg::csr_addr_w-1:0] ex_csr_addr;

    logic                            mem_rdy, mem_valid, mem_is_wr_rd, mem_is_csr;
    logic [core_pkg::xlen-1:0]       mem_pc, mem_result, mem_csr_new;
    logic [core_pkg::reg_idx_w-1:0]  mem_rd;
    logic [core_pkg::csr_addr_w-1:0] mem_csr_addr;

    logic                            wb_rdy, reg_we, csr_we;
    logic [core_pkg::reg_idx_w-1:0]  reg_idx;
    logic [core_pkg::xlen-1:0]       reg_data, csr_wdata, csr_rdata;
    logic [core_pkg::csr_addr_w-1:0] csr_addr;

    logic                            ex_fwd_valid, mem_fwd_valid, wb_fwd_valid;
    logic [core_pkg::reg_idx_w-1:0]  ex_fwd_idx, mem_fwd_idx, wb_fwd_idx;
    logic [core_pkg::xlen-1:0]       ex_fwd_data, mem_fwd_data, wb_fwd_data;

    decode_stage u_decode (
        .clk, .rst_n, .insn_valid, .insn, .insn_rdy, .next_rdy(ex_rdy),
        .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .ex_fwd_valid, .ex_fwd_idx, .ex_fwd_data,
        .mem_fwd_valid, .mem_fwd_idx, .mem_fwd_data,
        .wb_fwd_valid, .wb_fwd_idx, .wb_fwd_data,
        .ex_is_ld, .ex_is_csr, .mem_is_csr,
        .valid(id_valid), .pc(id_pc), .op(id_op), .rd(id_rd),
        .rj_val(id_rj_val), .rk_val(id_rk_val), .imm(id_imm), .csr_addr(id_csr_addr),
        .is_wr_rd(id_is_wr_rd), .is_ld(id_is_ld), .is_st(id_is_st), .is_csr(id_is_csr)
    );

    reg_file u_reg_file (
        .clk, .rst_n, .rs1_idx, .rs2_idx, .rs1_data, .rs2_data,
        .we(reg_we), .wr_idx(reg_idx), .wr_data(reg_data)
    );

    execute_stage u_execute (
        .clk, .rst_n, .rdy_in(ex_rdy), .next_rdy(mem_rdy),
        .id_valid, .id_pc, .id_rj_val, .id_rk_val, .id_imm, .id_op, .id_rd, .id_csr_addr,
        .id_is_wr_rd, .id_is_ld, .id_is_st, .id_is_csr,
        .valid(ex_valid), .pc(ex_pc), .result(ex_result), .st_data(ex_st_data),
        .rd(ex_rd), .csr_addr(ex_csr_addr), .is_wr_rd(ex_is_wr_rd), .is_ld(ex_is_ld),
        .is_st(ex_is_st), .is_csr(ex_is_csr),
        .fwd_valid(ex_fwd_valid), .fwd_idx(ex_fwd_idx), .fwd_data(ex_fwd_data)
    );

    memory_stage u_memory (
        .clk, .rst_n, .rdy_in(mem_rdy), .next_rdy(wb_rdy),
        .ex_valid, .ex_pc, .ex_result, .ex_st_data, .ex_rd, .ex_csr_addr,
        .ex_is_wr_rd, .ex_is_ld, .ex_is_st, .ex_is_csr,
        .valid(mem_valid), .pc(mem_pc), .result(mem_result), .csr_new(mem_csr_new),
        .rd(mem_rd), .csr_addr(mem_csr_addr), .is_wr_rd(mem_is_wr_rd), .is_csr(mem_is_csr),
        .fwd_valid(mem_fwd_valid), .fwd_idx(mem_fwd_idx), .fwd_data(mem_fwd_data)
    );

    writeback_stage u_writeback (
        .clk, .rst_n, .rdy_in(wb_rdy), .commit_rdy,
        .mem_valid, .mem_pc, .mem_result, .mem_csr_new, .mem_rd, .mem_csr_addr,
        .mem_is_wr_rd, .mem_is_csr, .csr_rdata,
        .reg_we, .csr_we, .reg_idx, .reg_data, .csr_wdata, .csr_addr,
        .fwd_valid(wb_fwd_valid), .fwd_idx(wb_fwd_idx), .fwd_data(wb_fwd_data),
        .commit_valid, .commit_wen, .commit_pc, .commit_data, .commit_rd
    );

    csr_file u_csr_file (
        .clk, .rst_n, .addr(csr_addr), .rdata(csr_rdata), .we(csr_we), .wdata(csr_wdata)
    );

endmodule

`default_nettype wire

// File: logic/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                            clk, rst_n,
    output logic                            rdy_in,
    input  logic                            commit_rdy,
    input  logic                            mem_valid,
    input  logic [core_pkg::xlen-1:0]       mem_pc, mem_result, mem_csr_new,
    input  logic [core_pkg::reg_idx_w-1:0]  mem_rd,
    input  logic [core_pkg::csr_addr_w-1:0] mem_csr_addr,
    input  logic                            mem_is_wr_rd, mem_is_csr,
    input  logic [core_pkg::xlen-1:0]       csr_rdata,
    output logic                            reg_we, csr_we,
    output logic [core_pkg::reg_idx_w-1:0]  reg_idx,
    output logic [core_pkg::xlen-1:0]       reg_data, csr_wdata,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            fwd_valid,
    output logic [core_pkg::reg_idx_w-1:0]  fwd_idx,
    output logic [core_pkg::xlen-1:0]       fwd_data,
    output logic                            commit_valid, commit_wen,
    output logic [core_pkg::xlen-1:0]       commit_pc, commit_data,
    output logic [core_pkg::reg_idx_w-1:0]  commit_rd
);

    logic                      fire;
    logic                      wr_r, csr_r;
    logic [core_pkg::xlen-1:0] result_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {commit_valid, wr_r, csr_r} <= '0;
        end else if (rdy_in) begin
            {commit_valid, wr_r, csr_r} <= {mem_valid, mem_is_wr_rd, mem_is_csr};
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            commit_pc <= mem_pc;
            reg_idx   <= mem_rd;
            result_r  <= mem_result;
            csr_wdata <= mem_csr_new;
            csr_addr  <= mem_csr_addr;
        end
    end

    assign fire   = commit_valid && commit_rdy;
    assign rdy_in = !commit_valid || commit_rdy;

    // CSRWR hands the old CSR value to rd
    assign reg_data = csr_r ? csr_rdata : result_r;
    assign reg_we   = fire && wr_r;
    assign csr_we   = fire && csr_r;

    // A held write still forwards since decode may move past it under back-pressure
    assign fwd_valid = wr_r;
    assign fwd_idx   = reg_idx;
    assign fwd_data  = reg_data;

    assign commit_wen  = wr_r;
    assign commit_rd   = wr_r ? reg_idx : '0;
    assign commit_data = wr_r ? reg_data : '0;

endmodule

`default_nettype wire

// File: logic/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
    input  logic                            clk, rst_n,
    output logic                            rdy_in,
    input  logic                            next_rdy,
    input  logic                            ex_valid,
    input  logic [core_pkg::xlen-1:0]       ex_pc, ex_result, ex_st_data,
    input  logic [core_pkg::reg_idx_w-1:0]  ex_rd,
    input  logic [core_pkg::csr_addr_w-1:0] ex_csr_addr,
    input  logic                            ex_is_wr_rd, ex_is_ld, ex_is_st, ex_is_csr,
    output logic                            valid,
    output logic [core_pkg::xlen-1:0]       pc, result, csr_new,
    output logic [core_pkg::reg_idx_w-1:0]  rd,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            is_wr_rd, is_csr,
    output logic                            fwd_valid,
    output logic [core_pkg::reg_idx_w-1:0]  fwd_idx,
    output logic [core_pkg::xlen-1:0]       fwd_data
);

    localparam int aw = $clog2(core_pkg::mem_words);

    logic [core_pkg::xlen-1:0] dmem [core_pkg::mem_words];
    logic [core_pkg::xlen-1:0] result_r;
    logic                      ld_r;

    assign rdy_in = !valid || next_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {valid, is_wr_rd, is_csr, ld_r} <= '0;
        end else if (rdy_in) begin
            {valid, is_wr_rd, is_csr, ld_r} <= {ex_valid, ex_is_wr_rd, ex_is_csr, ex_is_ld};
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            pc       <= ex_pc;
            rd       <= ex_rd;
            result_r <= ex_result;
            csr_addr <= ex_csr_addr;
        end
    end

    // Store lands as it enters the stage, so a following load sees it
    always_ff @(posedge clk) begin
        if (rdy_in && ex_is_st) begin
            dmem[ex_result[aw+1:2]] <= ex_st_data;
        end
    end

    assign result  = ld_r ? dmem[result_r[aw+1:2]] : result_r;
    assign csr_new = result_r;

    assign fwd_valid = is_wr_rd && !is_csr;
    assign fwd_idx   = rd;
    assign fwd_data  = result;

endmodule

`default_nettype wire

// File: logic/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic                            clk, rst_n,
    output logic                            rdy_in,
    input  logic                            next_rdy,
    input  logic                            id_valid,
    input  logic [core_pkg::xlen-1:0]       id_pc, id_rj_val, id_rk_val, id_imm,
    input  logic [core_pkg::op_w-1:0]       id_op,
    input  logic [core_pkg::reg_idx_w-1:0]  id_rd,
    input  logic [core_pkg::csr_addr_w-1:0] id_csr_addr,
    input  logic                            id_is_wr_rd, id_is_ld, id_is_st, id_is_csr,
    output logic                            valid,
    output logic [core_pkg::xlen-1:0]       pc, result, st_data,
    output logic [core_pkg::reg_idx_w-1:0]  rd,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            is_wr_rd, is_ld, is_st, is_csr,
    output logic                            fwd_valid,
    output logic [core_pkg::reg_idx_w-1:0]  fwd_idx,
    output logic [core_pkg::xlen-1:0]       fwd_data
);

    logic [core_pkg::op_w-1:0] op_r;
    logic [core_pkg::xlen-1:0] rj_r, rk_r, imm_r;

    assign rdy_in = !valid || next_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {valid, is_wr_rd, is_ld, is_st, is_csr} <= '0;
        end else if (rdy_in) begin
            {valid, is_wr_rd, is_ld, is_st, is_csr} <=
                {id_valid, id_is_wr_rd, id_is_ld, id_is_st, id_is_csr};
        end
    end

    always_ff @(posedge clk) begin
        if (rdy_in) begin
            pc       <= id_pc;
            op_r     <= id_op;
            rd       <= id_rd;
            rj_r     <= id_rj_val;
            rk_r     <= id_rk_val;
            imm_r    <= id_imm;
            csr_addr <= id_csr_addr;
        end
    end

    always_comb begin
        case (op_r)
            core_pkg::op_add: result = rj_r + rk_r;
            core_pkg::op_sub: result = rj_r - rk_r;
            core_pkg::op_and: result = rj_r & rk_r;
            core_pkg::op_or:  result = rj_r | rk_r;
            // Effective address for loads and stores
            core_pkg::op_addi, core_pkg::op_ldw, core_pkg::op_stw: result = rj_r + imm_r;
            default: result = rj_r;  // CSRWR carries the new CSR value down
        endcase
    end

    assign st_data = rk_r;

    assign fwd_valid = is_wr_rd && !is_ld && !is_csr;
    assign fwd_idx   = rd;
    assign fwd_data  = result;

endmodule

`default_nettype wire

// File: logic/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            clk, rst_n,
    input  logic                            insn_valid,
    input  core_pkg::insn_u                 insn,
    output logic                            insn_rdy,
    input  logic                            next_rdy,
    output logic [core_pkg::reg_idx_w-1:0]  rs1_idx, rs2_idx,
    input  logic [core_pkg::xlen-1:0]       rs1_data, rs2_data,
    input  logic                            ex_fwd_valid, mem_fwd_valid, wb_fwd_valid,
    input  logic [core_pkg::reg_idx_w-1:0]  ex_fwd_idx, mem_fwd_idx, wb_fwd_idx,
    input  logic [core_pkg::xlen-1:0]       ex_fwd_data, mem_fwd_data, wb_fwd_data,
    input  logic                            ex_is_ld, ex_is_csr, mem_is_csr,
    output logic                            valid,
    output logic [core_pkg::xlen-1:0]       pc,
    output logic [core_pkg::op_w-1:0]       op,
    output logic [core_pkg::reg_idx_w-1:0]  rd,
    output logic [core_pkg::xlen-1:0]       rj_val, rk_val, imm,
    output logic [core_pkg::csr_addr_w-1:0] csr_addr,
    output logic                            is_wr_rd, is_ld, is_st, is_csr
);

    logic                      valid_r;
    core_pkg::insn_u           insn_r;
    logic [core_pkg::xlen-1:0] pc_next;
    logic                      alu_rr;
    logic                      writes_rd;
    logic                      stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
            pc_next <= core_pkg::reset_pc;
        end else if (insn_rdy) begin
            valid_r <= insn_valid;
            if (insn_valid) begin
                pc_next <= pc_next + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (insn_rdy) begin
            insn_r <= insn;
            pc     <= pc_next;
        end
    end

    assign op        = insn_r.r.op;
    assign rd        = insn_r.r.rd;
    assign alu_rr    = op == core_pkg::op_add || op == core_pkg::op_sub ||
                       op == core_pkg::op_and || op == core_pkg::op_or;
    assign writes_rd = alu_rr || op == core_pkg::op_addi || op == core_pkg::op_ldw ||
                       op == core_pkg::op_csrwr;

    // ST.W takes its store data from the rd field
    assign rs1_idx = insn_r.r.rj;
    assign rs2_idx = (op == core_pkg::op_stw) ? insn_r.r.rd : insn_r.r.rk;

    // Youngest producer wins
    function automatic logic [core_pkg::xlen-1:0] resolve(
        input logic [core_pkg::reg_idx_w-1:0] idx,
        input logic [core_pkg::xlen-1:0]      rf_data
    );
        if (ex_fwd_valid && ex_fwd_idx == idx) return ex_fwd_data;
        if (mem_fwd_valid && mem_fwd_idx == idx) return mem_fwd_data;
        if (wb_fwd_valid && wb_fwd_idx == idx) return wb_fwd_data;
        return rf_data;
    endfunction

    // Load data and old CSR values appear too late to forward
    function automatic logic not_ready(input logic [core_pkg::reg_idx_w-1:0] idx);
        return idx != '0 && (((ex_is_ld || ex_is_csr) && ex_fwd_idx == idx) ||
                             (mem_is_csr && mem_fwd_idx == idx));
    endfunction

    always_comb begin
        rj_val = resolve(rs1_idx, rs1_data);
        rk_val = resolve(rs2_idx, rs2_data);
        stall  = valid_r && (not_ready(rs1_idx) ||
                 ((alu_rr || op == core_pkg::op_stw) && not_ready(rs2_idx)));
    end

    // A stall holds the register and lets a bubble go forward
    assign insn_rdy = !valid_r || (next_rdy && !stall);
    assign valid    = valid_r && !stall;

    assign imm      = {{(core_pkg::xlen-core_pkg::csr_addr_w){insn_r.i.imm12[11]}},
                       insn_r.i.imm12};
    assign csr_addr = insn_r.i.imm12;
    assign is_wr_rd = valid && writes_rd && rd != '0;
    assign is_ld    = valid && op == core_pkg::op_ldw;
    assign is_st    = valid && op == core_pkg::op_stw;
    assign is_csr   = valid && op == core_pkg::op_csrwr;

endmodule

`default_nettype wire

// File: logic/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                            clk, rst_n,
    input  logic [core_pkg::csr_addr_w-1:0] addr,
    output logic [core_pkg::xlen-1:0]       rdata,
    input  logic                            we,
    input  logic [core_pkg::xlen-1:0]       wdata
);

    logic [core_pkg::xlen-1:0] save [4];
    logic                      hit;
    logic [1:0]                sel;

    always_comb begin
        hit = 1'b1;
        sel = 2'd0;
        case (addr)
            core_pkg::csr_save0: sel = 2'd0;
            core_pkg::csr_save1: sel = 2'd1;
            core_pkg::csr_save2: sel = 2'd2;
            core_pkg::csr_save3: sel = 2'd3;
            default:             hit = 1'b0;
        endcase
    end

    // Unmapped addresses read as zero
    assign rdata = hit ? save[sel] : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 4; k++) begin
                save[k] <= '0;
            end
        end else if (we && hit) begin
            save[sel] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                           clk, rst_n,
    input  logic [core_pkg::reg_idx_w-1:0] rs1_idx, rs2_idx,
    output logic [core_pkg::xlen-1:0]      rs1_data, rs2_data,
    input  logic                           we,
    input  logic [core_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [core_pkg::xlen-1:0]      wr_data
);

    logic [core_pkg::xlen-1:0] regs [2**core_pkg::reg_idx_w];

    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    // r0 is cleared by reset and never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < 2**core_pkg::reg_idx_w; k++) begin
                regs[k] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: logic/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen       = 32;
    localparam int reg_idx_w  = 5;
    localparam int csr_addr_w = 12;
    localparam int op_w       = 6;
    localparam int mem_words  = 256;

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // Major opcode in bits 31:26
    localparam logic [op_w-1:0] op_add   = 6'd1;
    localparam logic [op_w-1:0] op_sub   = 6'd2;
    localparam logic [op_w-1:0] op_and   = 6'd3;
    localparam logic [op_w-1:0] op_or    = 6'd4;
    localparam logic [op_w-1:0] op_addi  = 6'd8;
    localparam logic [op_w-1:0] op_ldw   = 6'd9;
    localparam logic [op_w-1:0] op_stw   = 6'd10;
    localparam logic [op_w-1:0] op_csrwr = 6'd12;

    localparam logic [csr_addr_w-1:0] csr_save0 = 12'h030;
    localparam logic [csr_addr_w-1:0] csr_save1 = 12'h031;
    localparam logic [csr_addr_w-1:0] csr_save2 = 12'h032;
    localparam logic [csr_addr_w-1:0] csr_save3 = 12'h033;

    // Register form and immediate form share op, rj and rd
    typedef union packed {
        struct packed {
            logic [op_w-1:0]      op;
            logic [10:0]          unused;
            logic [reg_idx_w-1:0] rk;
            logic [reg_idx_w-1:0] rj;
            logic [reg_idx_w-1:0] rd;
        } r;
        struct packed {
            logic [op_w-1:0]       op;
            logic [3:0]            unused;
            logic [csr_addr_w-1:0] imm12;
            logic [reg_idx_w-1:0]  rj;
            logic [reg_idx_w-1:0]  rd;
        } i;
    } insn_u;

endpackage

`default_nettype wire
